// File: common/mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 6;
    localparam int funct_w    = 6;
    localparam int imm_w      = 16;

    // primary opcode field, instr[31:26]
    typedef enum logic [opcode_w-1:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d
    } opcode_e;

    // function field of R-type words, instr[5:0]
    typedef enum logic [funct_w-1:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    // internal ALU operation select
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

    import mips_isa_pkg::*;

    typedef struct packed {
        logic    reg_write;
        logic    alu_src;
        logic    reg_dest;
        logic    branch;
        alu_op_e alu_op;
    } ctrl_t;

    // decode to execute, immediate is already extended
    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [data_w-1:0]     pc;
        logic [data_w-1:0]     data_a;
        logic [data_w-1:0]     data_b;
        logic [data_w-1:0]     immediate;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic [data_w-1:0]     pc;
        logic [reg_addr_w-1:0] dest;
        logic                  reg_write;
        logic [data_w-1:0]     result;
        logic                  branch_taken;
        logic [data_w-1:0]     branch_target;
    } ex_res_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
        logic [data_w-1:0]     data;
    } wb_t;

endpackage

// File: decode/register_file.sv
module register_file (
    input  logic                                i_clock,
    input  logic                                rst_n,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] rt_addr,
    output logic [mips_isa_pkg::data_w-1:0]     rs_data,
    output logic [mips_isa_pkg::data_w-1:0]     rt_data,
    input  pipe_pkg::wb_t                       wb
);

    import mips_isa_pkg::*;

    localparam int num_regs = 1 << reg_addr_w;

    logic [data_w-1:0] regs [num_regs];

    always_ff @(posedge i_clock) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            // r0 is never written so it keeps its reset value
            regs[wb.addr] <= wb.data;
        end
    end

    // read ports are combinational
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: decode/decode_stage.sv
module decode_stage (
    input  logic                                i_clock,
    input  logic                                rst_n,
    input  logic                                in_req,
    input  logic [mips_isa_pkg::data_w-1:0]     in_instr,
    input  logic [mips_isa_pkg::data_w-1:0]     in_pc,
    output logic                                in_ack,
    input  logic                                stall,
    input  logic                                pend_a_valid,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] pend_a_dest,
    input  logic                                pend_b_valid,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] pend_b_dest,
    input  pipe_pkg::wb_t                       wb,
    output pipe_pkg::id_ex_t                    id_out
);

    import mips_isa_pkg::*;
    import pipe_pkg::*;

    logic                  slot_valid;
    logic [data_w-1:0]     slot_instr;
    logic [data_w-1:0]     slot_pc;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [imm_w-1:0]      imm;
    logic [data_w-1:0]     rs_data;
    logic [data_w-1:0]     rt_data;
    logic [data_w-1:0]     imm_ext;
    logic                  zero_ext;
    logic                  uses_rs;
    logic                  uses_rt;
    logic                  rs_hit;
    logic                  rt_hit;
    logic                  hazard;
    ctrl_t                 ctrl;

    // four-phase input, one word held in the slot until id_ex takes it
    always_ff @(posedge i_clock) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
            in_ack     <= 1'b0;
        end else if (in_req && !in_ack && !slot_valid) begin
            slot_valid <= 1'b1;
            slot_instr <= in_instr;
            slot_pc    <= in_pc;
            in_ack     <= 1'b1;
        end else begin
            if (!in_req && in_ack) begin
                in_ack <= 1'b0;
            end
            if (slot_valid && !hazard && !stall) begin
                slot_valid <= 1'b0;
            end
        end
    end

    assign rs  = slot_instr[25:21];
    assign rt  = slot_instr[20:16];
    assign rd  = slot_instr[15:11];
    assign imm = slot_instr[15:0];

    always_comb begin
        ctrl     = '0;
        zero_ext = 1'b0;
        uses_rs  = 1'b0;
        uses_rt  = 1'b0;
        case (opcode_e'(slot_instr[31:26]))
            op_rtype: begin
                uses_rs       = 1'b1;
                uses_rt       = 1'b1;
                ctrl.reg_dest = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct_e'(slot_instr[5:0]))
                    fn_add:  ctrl.alu_op = alu_add;
                    fn_sub:  ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    // unknown funct retires as a nop
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            op_addi, op_andi, op_ori: begin
                uses_rs        = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                if (slot_instr[31:26] == op_andi) begin
                    ctrl.alu_op = alu_and;
                    zero_ext    = 1'b1;
                end else if (slot_instr[31:26] == op_ori) begin
                    ctrl.alu_op = alu_or;
                    zero_ext    = 1'b1;
                end
            end
            op_beq: begin
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;
            end
            default: ;
        endcase
    end

    assign imm_ext = zero_ext ? {{(data_w-imm_w){1'b0}}, imm}
                              : {{(data_w-imm_w){imm[imm_w-1]}}, imm};

    // raw interlock against id_ex and the result holding register
    assign rs_hit = uses_rs && rs != '0 &&
                    ((pend_a_valid && pend_a_dest == rs) || (pend_b_valid && pend_b_dest == rs));
    assign rt_hit = uses_rt && rt != '0 &&
                    ((pend_a_valid && pend_a_dest == rt) || (pend_b_valid && pend_b_dest == rt));
    assign hazard = rs_hit || rt_hit;

    register_file u_regs (
        .i_clock (i_clock),
        .rst_n   (rst_n),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    always_comb begin
        id_out.valid     = slot_valid && !hazard;
        id_out.ctrl      = ctrl;
        id_out.pc        = slot_pc;
        id_out.data_a    = rs_data;
        id_out.data_b    = rt_data;
        id_out.immediate = imm_ext;
        id_out.rt        = rt;
        id_out.rd        = rd;
    end

    ack_after_req: assert property (
        @(posedge i_clock) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req)
    );

endmodule

// File: verilog/id_ex_reg.sv
module id_ex_reg (
    input  logic             i_clock,
    input  logic             rst_n,
    input  logic             stall,
    input  pipe_pkg::id_ex_t id_in,
    output pipe_pkg::id_ex_t ex_out
);

    // controls are cleared for reset and bubbles, payload only loads
    always_ff @(posedge i_clock) begin
        if (!rst_n) begin
            ex_out.valid <= 1'b0;
            ex_out.ctrl  <= '0;
        end else if (!stall) begin
            if (id_in.valid) begin
                ex_out <= id_in;
            end else begin
                ex_out.valid <= 1'b0;
                ex_out.ctrl  <= '0;
            end
        end
    end

    // a bubble must never write or branch downstream
    bubble_is_inert: assert property (
        @(posedge i_clock) disable iff (!rst_n)
        !ex_out.valid |-> (!ex_out.ctrl.reg_write && !ex_out.ctrl.branch)
    );

endmodule

// File: execute/execute_stage.sv
module execute_stage (
    input  pipe_pkg::id_ex_t  ex_in,
    output logic              res_valid,
    output pipe_pkg::ex_res_t res
);

    import mips_isa_pkg::*;

    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] alu_out;
    logic [data_w-1:0] pc_plus4;
    logic              lt;

    assign op_a = ex_in.data_a;
    // immediate already extended in decode
    assign op_b = ex_in.ctrl.alu_src ? ex_in.immediate : ex_in.data_b;

    assign lt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (ex_in.ctrl.alu_op)
            alu_add: alu_out = op_a + op_b;
            alu_sub: alu_out = op_a - op_b;
            alu_and: alu_out = op_a & op_b;
            alu_or:  alu_out = op_a | op_b;
            alu_slt: alu_out = {{(data_w-1){1'b0}}, lt};
            default: alu_out = '0;
        endcase
    end

    assign pc_plus4 = ex_in.pc + data_w'(4);

    assign res_valid = ex_in.valid;

    always_comb begin
        res.pc        = ex_in.pc;
        res.dest      = ex_in.ctrl.reg_dest ? ex_in.rd : ex_in.rt;
        // gated with valid so it can serve directly as the pending flag
        res.reg_write = ex_in.valid && ex_in.ctrl.reg_write;
        res.result    = alu_out;
        // beq compares the registers, never the immediate
        res.branch_taken  = ex_in.valid && ex_in.ctrl.branch &&
                            (ex_in.data_a == ex_in.data_b);
        res.branch_target = pc_plus4 + {ex_in.immediate[data_w-3:0], 2'b00};
    end

endmodule

// File: verilog/result_port.sv
module result_port (
    input  logic                                i_clock,
    input  logic                                rst_n,
    input  logic                                res_valid,
    input  pipe_pkg::ex_res_t                   res,
    output logic                                busy,
    output logic                                pend_valid,
    output logic [mips_isa_pkg::reg_addr_w-1:0] pend_dest,
    output pipe_pkg::wb_t                       wb,
    output logic                                out_req,
    output pipe_pkg::ex_res_t                   out_res,
    input  logic                                out_ack
);

    typedef enum logic [1:0] {
        rp_empty,
        rp_req,
        rp_drop
    } rp_state_e;

    rp_state_e state;

    always_ff @(posedge i_clock) begin
        if (!rst_n) begin
            state <= rp_empty;
        end else begin
            case (state)
                rp_empty: begin
                    if (res_valid) begin
                        out_res <= res;
                        state   <= rp_req;
                    end
                end
                rp_req: begin
                    if (out_ack) begin
                        state <= rp_drop;
                    end
                end
                rp_drop: begin
                    // slot frees only once the consumer has released ack
                    if (!out_ack) begin
                        state <= rp_empty;
                    end
                end
                default: state <= rp_empty;
            endcase
        end
    end

    assign out_req = (state == rp_req);
    assign busy    = (state != rp_empty);

    // still pending until the write-back cycle
    assign pend_valid = out_req && !out_ack && out_res.reg_write;
    assign pend_dest  = out_res.dest;

    // single write-back, the one cycle ack is seen high in rp_req
    always_comb begin
        wb.en   = out_req && out_ack && out_res.reg_write && (out_res.dest != '0);
        wb.addr = out_res.dest;
        wb.data = out_res.result;
    end

    req_held_until_ack: assert property (
        @(posedge i_clock) disable iff (!rst_n)
        $fell(out_req) |-> $past(out_ack)
    );

endmodule

// File: verilog/mips_ex_top.sv
module mips_ex_top (
    input  logic                            i_clock,
    input  logic                            rst_n,
    input  logic                            in_req,
    input  logic [mips_isa_pkg::data_w-1:0] in_instr,
    input  logic [mips_isa_pkg::data_w-1:0] in_pc,
    output logic                            in_ack,
    output logic                            out_req,
    output pipe_pkg::ex_res_t               out_res,
    input  logic                            out_ack
);

    import mips_isa_pkg::*;
    import pipe_pkg::*;

    id_ex_t                id_out;
    id_ex_t                ex_out;
    ex_res_t               res;
    logic                  res_valid;
    logic                  busy;
    logic                  rp_pend_valid;
    logic [reg_addr_w-1:0] rp_pend_dest;
    wb_t                   wb;

    // id_ex pending dest comes from execute, where it is already resolved
    decode_stage u_decode (
        .i_clock      (i_clock),
        .rst_n        (rst_n),
        .in_req       (in_req),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .in_ack       (in_ack),
        .stall        (busy),
        .pend_a_valid (res.reg_write),
        .pend_a_dest  (res.dest),
        .pend_b_valid (rp_pend_valid),
        .pend_b_dest  (rp_pend_dest),
        .wb           (wb),
        .id_out       (id_out)
    );

    id_ex_reg u_id_ex (
        .i_clock (i_clock),
        .rst_n   (rst_n),
        .stall   (busy),
        .id_in   (id_out),
        .ex_out  (ex_out)
    );

    execute_stage u_execute (
        .ex_in     (ex_out),
        .res_valid (res_valid),
        .res       (res)
    );

    result_port u_result (
        .i_clock    (i_clock),
        .rst_n      (rst_n),
        .res_valid  (res_valid),
        .res        (res),
        .busy       (busy),
        .pend_valid (rp_pend_valid),
        .pend_dest  (rp_pend_dest),
        .wb         (wb),
        .out_req    (out_req),
        .out_res    (out_res),
        .out_ack    (out_ack)
    );

endmodule

// File: testbench/tb_mips_ex.sv
module tb_mips_ex;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;
    import pipe_pkg::*;

    localparam int          max_wait = 200;
    localparam logic [31:0] base_pc  = 32'h0000_0100;

    typedef struct packed {
        logic [31:0] instr;
        logic        is_branch;
        ex_res_t     exp;
    } vector_t;

    logic              i_clock = 1'b0;
    logic              rst_n;
    logic              in_req;
    logic [data_w-1:0] in_instr;
    logic [data_w-1:0] in_pc;
    logic              in_ack;
    logic              out_req;
    ex_res_t           out_res;
    logic              out_ack;

    vector_t vectors[$];

    mips_ex_top i_dut (
        .i_clock  (i_clock),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_res  (out_res),
        .out_ack  (out_ack)
    );

    always #2 i_clock = ~i_clock;

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] funct);
        return {op_rtype, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_alu(input logic [31:0] instr, input logic [4:0] dest,
                           input logic [31:0] result);
        vector_t v;
        v               = '0;
        v.instr         = instr;
        v.exp.pc        = base_pc + 32'(4 * vectors.size());
        v.exp.dest      = dest;
        v.exp.reg_write = 1'b1;
        v.exp.result    = result;
        vectors.push_back(v);
    endtask

    task automatic add_beq(input logic [31:0] instr, input logic taken,
                           input logic [31:0] target);
        vector_t v;
        v                   = '0;
        v.instr             = instr;
        v.is_branch         = 1'b1;
        v.exp.pc            = base_pc + 32'(4 * vectors.size());
        v.exp.branch_taken  = taken;
        v.exp.branch_target = target;
        vectors.push_back(v);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t %s: got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: timed out at %0t waiting for %s", $time, what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic wait_in_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge i_clock);
        while (in_ack !== level) begin
            cycles++;
            if (cycles > max_wait) report_timeout("in_ack");
            @(negedge i_clock);
        end
    endtask

    task automatic wait_out_req(input logic level);
        int cycles;
        cycles = 0;
        @(negedge i_clock);
        while (out_req !== level) begin
            cycles++;
            if (cycles > max_wait) report_timeout("out_req");
            @(negedge i_clock);
        end
    endtask

    // one four-phase transfer on the instruction port
    task automatic send_instr(input logic [31:0] instr, input logic [31:0] pc);
        @(posedge i_clock);
        in_instr <= instr;
        in_pc    <= pc;
        in_req   <= 1'b1;
        wait_in_ack(1'b1);
        @(posedge i_clock);
        in_req <= 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic compare_result(input int idx);
        vector_t v;
        v = vectors[idx];
        check_value("out_res.pc", out_res.pc, v.exp.pc);
        check_value("out_res.reg_write", 32'(out_res.reg_write), 32'(v.exp.reg_write));
        check_value("out_res.branch_taken", 32'(out_res.branch_taken),
                    32'(v.exp.branch_taken));
        if (v.is_branch) begin
            check_value("out_res.branch_target", out_res.branch_target, v.exp.branch_target);
        end else begin
            check_value("out_res.dest", 32'(out_res.dest), 32'(v.exp.dest));
            check_value("out_res.result", out_res.result, v.exp.result);
        end
    endtask

    // random ack delay keeps the pipeline backed up
    task automatic take_result(input int idx);
        int delay;
        wait_out_req(1'b1);
        compare_result(idx);
        delay = $urandom % 6;
        repeat (delay) @(posedge i_clock);
        @(posedge i_clock);
        out_ack <= 1'b1;
        wait_out_req(1'b0);
        @(posedge i_clock);
        out_ack <= 1'b0;
    endtask

    initial begin
        rst_n    = 1'b0;
        in_req   = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        out_ack  = 1'b0;
        void'($urandom(32'h7a57_e6b7));

        // registers all start at zero
        add_alu(enc_r(5'd5, 5'd6, 5'd1, fn_add), 5'd1, 32'h0000_0000);
        add_alu(enc_i(op_addi, 5'd0, 5'd2, 16'h0005), 5'd2, 32'h0000_0005);
        add_alu(enc_i(op_addi, 5'd0, 5'd3, 16'hfffd), 5'd3, 32'hffff_fffd);
        add_alu(enc_i(op_andi, 5'd3, 5'd4, 16'hf0f0), 5'd4, 32'h0000_f0f0);
        add_alu(enc_i(op_ori, 5'd2, 5'd5, 16'h8000), 5'd5, 32'h0000_8005);
        add_alu(enc_r(5'd2, 5'd3, 5'd6, fn_add), 5'd6, 32'h0000_0002);
        add_alu(enc_r(5'd6, 5'd2, 5'd7, fn_sub), 5'd7, 32'hffff_fffd);
        add_alu(enc_r(5'd7, 5'd5, 5'd8, fn_and), 5'd8, 32'h0000_8005);
        add_alu(enc_r(5'd4, 5'd2, 5'd9, fn_or), 5'd9, 32'h0000_f0f5);
        add_alu(enc_r(5'd3, 5'd2, 5'd10, fn_slt), 5'd10, 32'h0000_0001);
        add_alu(enc_r(5'd2, 5'd3, 5'd11, fn_slt), 5'd11, 32'h0000_0000);
        // write to r0 must be dropped
        add_alu(enc_i(op_addi, 5'd0, 5'd0, 16'h0007), 5'd0, 32'h0000_0007);
        add_alu(enc_r(5'd0, 5'd2, 5'd12, fn_add), 5'd12, 32'h0000_0005);
        add_beq(enc_i(op_beq, 5'd2, 5'd5, 16'h0003), 1'b0, 32'h0000_0144);
        add_beq(enc_i(op_beq, 5'd7, 5'd3, 16'hfffe), 1'b1, 32'h0000_0134);
        add_alu(enc_r(5'd7, 5'd0, 5'd13, fn_slt), 5'd13, 32'h0000_0001);
        add_alu(enc_r(5'd0, 5'd6, 5'd14, fn_sub), 5'd14, 32'hffff_fffe);

        repeat (3) @(posedge i_clock);
        rst_n <= 1'b1;
        @(negedge i_clock);
        check_value("in_ack", 32'(in_ack), 32'h0);
        check_value("out_req", 32'(out_req), 32'h0);

        fork
            begin
                for (int i = 0; i < vectors.size(); i++) begin
                    send_instr(vectors[i].instr, vectors[i].exp.pc);
                end
            end
            begin
                for (int i = 0; i < vectors.size(); i++) begin
                    take_result(i);
                end
            end
        join

        // nothing may follow the last expected result
        for (int i = 0; i < 20; i++) begin
            @(negedge i_clock);
            if (out_req !== 1'b0) begin
                $display("ERROR: an extra result appeared after the last expected one");
                $display("TEST FAIL");
                $fatal(1);
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: files.f
common/mips_isa_pkg.sv
common/pipe_pkg.sv
decode/register_file.sv
decode/decode_stage.sv
verilog/id_ex_reg.sv
execute/execute_stage.sv
verilog/result_port.sv
verilog/mips_ex_top.sv
testbench/tb_mips_ex.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_mips_ex \
    -Mdir obj_dir -o tb_mips_ex
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_mips_ex > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
